// ==== rv_isa_pkg.sv ====
/*
 * RV32 ISA definitions
 * Opcodes, instruction formats and the decoded operation set
 */

package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Bits 1:0 of every 32-bit encoding
    localparam logic [1:0] ILEN_LOW_BITS = 2'b11;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } format_e;

    // NOP first so the bubble encodes as zero
    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,   // ALU
        BEQ, BNE, BLT, BGE, BLTU, BGEU,                     // Branches
        LB, LH, LW, LBU, LHU,                               // Loads
        SB, SH, SW,                                         // Stores
        LUI, AUIPC, JAL, JALR,
        ECALL, EBREAK, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,     // M extension
        INVALID
    } op_e;

endpackage

// ==== decode_pkg.sv ====
/*
 * Decode stage types
 * Packets between fetch, register file, forwarding paths and execute
 */

package decode_pkg;

    typedef logic [rv_isa_pkg::XLEN-1:0]       xlen_t;
    typedef logic [rv_isa_pkg::REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        xlen_t instr;
        xlen_t pc;
        logic  access_fault;   // Bus error on the fetch
    } fetch_packet_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } retire_fwd_t;

    // Destination is the rd last issued
    typedef struct packed {
        logic  we;
        xlen_t result;
    } exec_fwd_t;

    typedef struct packed {
        rv_isa_pkg::op_e op;
        reg_addr_t       rd;
        xlen_t           rs1_data;
        xlen_t           rs2_data;
        xlen_t           second;
        xlen_t           pc;
        xlen_t           instr;
        xlen_t           target;   // pc + immediate
        xlen_t           link;     // pc + 4
    } issue_packet_t;

    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic access_fault;
    } exc_flags_t;

endpackage

// ==== op_decoder.sv ====
/*
 * Operation decoder
 * Maps opcode, funct3 and funct7 onto the operation and format
 */

`timescale 1ns/1ns

module op_decoder #(
    parameter bit MUL_ENABLE = 1'b1
) (
    input  decode_pkg::xlen_t   instr_i,
    output rv_isa_pkg::op_e     op_o,
    output rv_isa_pkg::format_e format_o,
    output logic                illegal_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_isa_pkg::op_e     dec_branch;
    rv_isa_pkg::op_e     dec_load;
    rv_isa_pkg::op_e     dec_store;
    rv_isa_pkg::op_e     dec_op_imm;
    rv_isa_pkg::op_e     dec_op;
    rv_isa_pkg::op_e     dec_mul;
    rv_isa_pkg::op_e     dec_system;

    assign opcode = rv_isa_pkg::opcode_e'(instr_i[6:2]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Per-class tables
    ////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  dec_branch = rv_isa_pkg::BEQ;
            3'b001:  dec_branch = rv_isa_pkg::BNE;
            3'b100:  dec_branch = rv_isa_pkg::BLT;
            3'b101:  dec_branch = rv_isa_pkg::BGE;
            3'b110:  dec_branch = rv_isa_pkg::BLTU;
            3'b111:  dec_branch = rv_isa_pkg::BGEU;
            default: dec_branch = rv_isa_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_load = rv_isa_pkg::LB;
            3'b001:  dec_load = rv_isa_pkg::LH;
            3'b010:  dec_load = rv_isa_pkg::LW;
            3'b100:  dec_load = rv_isa_pkg::LBU;
            3'b101:  dec_load = rv_isa_pkg::LHU;
            default: dec_load = rv_isa_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_store = rv_isa_pkg::SB;
            3'b001:  dec_store = rv_isa_pkg::SH;
            3'b010:  dec_store = rv_isa_pkg::SW;
            default: dec_store = rv_isa_pkg::INVALID;
        endcase
    end

    // Shift amounts only take the plain or arithmetic funct7
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = rv_isa_pkg::ADD;
            10'b0000000001: dec_op_imm = rv_isa_pkg::SLL;
            10'b???????010: dec_op_imm = rv_isa_pkg::SLT;
            10'b???????011: dec_op_imm = rv_isa_pkg::SLTU;
            10'b???????100: dec_op_imm = rv_isa_pkg::XOR;
            10'b0000000101: dec_op_imm = rv_isa_pkg::SRL;
            10'b0100000101: dec_op_imm = rv_isa_pkg::SRA;
            10'b???????110: dec_op_imm = rv_isa_pkg::OR;
            10'b???????111: dec_op_imm = rv_isa_pkg::AND;
            default:        dec_op_imm = rv_isa_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_mul = rv_isa_pkg::MUL;
            3'b001:  dec_mul = rv_isa_pkg::MULH;
            3'b010:  dec_mul = rv_isa_pkg::MULHSU;
            3'b011:  dec_mul = rv_isa_pkg::MULHU;
            3'b100:  dec_mul = rv_isa_pkg::DIV;
            3'b101:  dec_mul = rv_isa_pkg::DIVU;
            3'b110:  dec_mul = rv_isa_pkg::REM;
            default: dec_mul = rv_isa_pkg::REMU;
        endcase
    end

    always_comb begin
        case ({funct7, funct3}) inside
            10'b0000000000: dec_op = rv_isa_pkg::ADD;
            10'b0100000000: dec_op = rv_isa_pkg::SUB;
            10'b0000000001: dec_op = rv_isa_pkg::SLL;
            10'b0000000010: dec_op = rv_isa_pkg::SLT;
            10'b0000000011: dec_op = rv_isa_pkg::SLTU;
            10'b0000000100: dec_op = rv_isa_pkg::XOR;
            10'b0000000101: dec_op = rv_isa_pkg::SRL;
            10'b0100000101: dec_op = rv_isa_pkg::SRA;
            10'b0000000110: dec_op = rv_isa_pkg::OR;
            10'b0000000111: dec_op = rv_isa_pkg::AND;
            10'b0000001???: dec_op = MUL_ENABLE ? dec_mul : rv_isa_pkg::INVALID;
            default:        dec_op = rv_isa_pkg::INVALID;
        endcase
    end

    // Privileged encodings need every other field zero
    always_comb begin
        case (instr_i[31:7]) inside
            25'h0000000:                    dec_system = rv_isa_pkg::ECALL;
            25'h0002000:                    dec_system = rv_isa_pkg::EBREAK;
            25'h0604000:                    dec_system = rv_isa_pkg::MRET;
            25'h020a000:                    dec_system = rv_isa_pkg::WFI;
            25'b?????????????????001?????: dec_system = rv_isa_pkg::CSRRW;
            25'b?????????????????010?????: dec_system = rv_isa_pkg::CSRRS;
            25'b?????????????????011?????: dec_system = rv_isa_pkg::CSRRC;
            25'b?????????????????101?????: dec_system = rv_isa_pkg::CSRRWI;
            25'b?????????????????110?????: dec_system = rv_isa_pkg::CSRRSI;
            25'b?????????????????111?????: dec_system = rv_isa_pkg::CSRRCI;
            default:                        dec_system = rv_isa_pkg::INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Opcode select and format
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_LUI:      op_o = rv_isa_pkg::LUI;
            rv_isa_pkg::OPC_AUIPC:    op_o = rv_isa_pkg::AUIPC;
            rv_isa_pkg::OPC_JAL:      op_o = rv_isa_pkg::JAL;
            rv_isa_pkg::OPC_JALR:     op_o = rv_isa_pkg::JALR;
            rv_isa_pkg::OPC_BRANCH:   op_o = dec_branch;
            rv_isa_pkg::OPC_LOAD:     op_o = dec_load;
            rv_isa_pkg::OPC_STORE:    op_o = dec_store;
            rv_isa_pkg::OPC_OP_IMM:   op_o = dec_op_imm;
            rv_isa_pkg::OPC_OP:       op_o = dec_op;
            rv_isa_pkg::OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? rv_isa_pkg::NOP  // FENCE
                                                                : rv_isa_pkg::INVALID;
            rv_isa_pkg::OPC_SYSTEM:   op_o = dec_system;
            default:                  op_o = rv_isa_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_JALR,
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_OP_IMM: format_o = rv_isa_pkg::FMT_I;
            rv_isa_pkg::OPC_STORE:  format_o = rv_isa_pkg::FMT_S;
            rv_isa_pkg::OPC_BRANCH: format_o = rv_isa_pkg::FMT_B;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:  format_o = rv_isa_pkg::FMT_U;
            rv_isa_pkg::OPC_JAL:    format_o = rv_isa_pkg::FMT_J;
            default:                format_o = rv_isa_pkg::FMT_R;   // OP, SYSTEM, FENCE
        endcase
    end

    assign illegal_o = (instr_i[1:0] != rv_isa_pkg::ILEN_LOW_BITS)
                    || (op_o == rv_isa_pkg::INVALID);

endmodule

// ==== operand_unit.sv ====
/*
 * Operand unit
 * Immediate extraction, forwarding of both sources and jump target
 */

`timescale 1ns/1ns

module operand_unit (
    input  decode_pkg::xlen_t       instr_i,
    input  decode_pkg::xlen_t       pc_i,
    input  rv_isa_pkg::format_e     format_i,
    input  decode_pkg::xlen_t       rs1_data_i,
    input  decode_pkg::xlen_t       rs2_data_i,
    input  decode_pkg::retire_fwd_t retire_i,
    input  decode_pkg::exec_fwd_t   exec_i,
    input  decode_pkg::reg_addr_t   issued_rd_i,
    output decode_pkg::xlen_t       rs1_val_o,
    output decode_pkg::xlen_t       rs2_val_o,
    output decode_pkg::xlen_t       second_o,
    output decode_pkg::xlen_t       target_o
);

    decode_pkg::xlen_t imm;

    // Execute beats retire beats register file, x0 always from the file
    function automatic decode_pkg::xlen_t forward(
        input decode_pkg::reg_addr_t   src,
        input decode_pkg::xlen_t       rf_data,
        input decode_pkg::exec_fwd_t   ex,
        input decode_pkg::reg_addr_t   ex_rd,
        input decode_pkg::retire_fwd_t rt
    );
        decode_pkg::xlen_t val;
        if (src == '0)
            val = rf_data;
        else if (ex.we && src == ex_rd)
            val = ex.result;
        else if (rt.we && src == rt.rd)
            val = rt.data;
        else
            val = rf_data;
        return val;
    endfunction

    ////////////////////////////////////////
    // Immediate per format
    ////////////////////////////////////////

    always_comb begin
        case (format_i)
            rv_isa_pkg::FMT_I: imm = {{21{instr_i[31]}}, instr_i[30:20]};
            rv_isa_pkg::FMT_S: imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            rv_isa_pkg::FMT_B: imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                      instr_i[11:8], 1'b0};
            rv_isa_pkg::FMT_U: imm = {instr_i[31:12], 12'b0};
            rv_isa_pkg::FMT_J: imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                      instr_i[30:21], 1'b0};
            default:           imm = '0;   // R format
        endcase
    end

    assign rs1_val_o = forward(instr_i[19:15], rs1_data_i, exec_i, issued_rd_i, retire_i);
    assign rs2_val_o = forward(instr_i[24:20], rs2_data_i, exec_i, issued_rd_i, retire_i);

    always_comb begin
        case (format_i)
            rv_isa_pkg::FMT_I,
            rv_isa_pkg::FMT_S,
            rv_isa_pkg::FMT_U: second_o = imm;
            default:           second_o = rs2_val_o;
        endcase
    end

    assign target_o = pc_i + imm;   // Branch and JAL target

endmodule

// ==== hazard_unit.sv ====
/*
 * Hazard unit
 * Load-lock and store flag tracking, exception and kill conditions
 */

`timescale 1ns/1ns

module hazard_unit #(
    parameter bit COMPRESSED = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  decode_pkg::xlen_t      instr_i,
    input  rv_isa_pkg::format_e    format_i,
    input  logic                   flush_i,
    input  logic                   access_fault_i,
    input  logic                   illegal_i,
    input  decode_pkg::xlen_t      pc_i,
    output logic                   hazard_o,
    output logic                   killed_o,
    output decode_pkg::exc_flags_t exc_o
);

    decode_pkg::reg_addr_t lock_reg;     // rd of the load in execute
    logic                  store_flag;
    logic                  is_load;
    logic                  is_store;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  misaligned;
    logic                  exception;

    assign is_load  = (instr_i[6:2] == rv_isa_pkg::OPC_LOAD);
    assign is_store = (instr_i[6:2] == rv_isa_pkg::OPC_STORE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lock_reg   <= '0;
            store_flag <= 1'b0;
        end else if (enable_i) begin
            if (hazard_o || killed_o) begin
                lock_reg   <= '0;
                store_flag <= 1'b0;
            end else begin
                lock_reg   <= is_load ? instr_i[11:7] : '0;
                store_flag <= is_store;
            end
        end
    end

    ////////////////////////////////////////
    // Hazard and exceptions
    ////////////////////////////////////////

    assign use_rs1 = (format_i inside {rv_isa_pkg::FMT_R, rv_isa_pkg::FMT_I,
                                       rv_isa_pkg::FMT_S, rv_isa_pkg::FMT_B});
    assign use_rs2 = (format_i inside {rv_isa_pkg::FMT_R, rv_isa_pkg::FMT_S,
                                       rv_isa_pkg::FMT_B});

    // Halfword fetch is legal with compressed support
    assign misaligned = COMPRESSED ? pc_i[0] : (pc_i[1:0] != 2'b00);
    assign exception  = illegal_i || misaligned || access_fault_i;

    assign killed_o = flush_i;

    // x0 in the lock register means nothing is locked
    assign hazard_o = ((lock_reg != '0 && use_rs1 && lock_reg == instr_i[19:15])
                    || (lock_reg != '0 && use_rs2 && lock_reg == instr_i[24:20])
                    || (store_flag && is_load))
                    && !killed_o && !exception;

    assign exc_o = '{illegal: illegal_i, misaligned: misaligned, access_fault: access_fault_i};

endmodule

// ==== issue_reg.sv ====
/*
 * Issue register
 * Packet to execute, with NOP bubbles on hazard or kill
 */

`timescale 1ns/1ns

module issue_reg (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      hazard_i,
    input  logic                      killed_i,
    input  rv_isa_pkg::op_e           op_i,
    input  decode_pkg::fetch_packet_t instr_i,
    input  decode_pkg::xlen_t         rs1_val_i,
    input  decode_pkg::xlen_t         rs2_val_i,
    input  decode_pkg::xlen_t         second_i,
    input  decode_pkg::xlen_t         target_i,
    input  decode_pkg::exc_flags_t    exc_i,
    output decode_pkg::issue_packet_t issue_o,
    output decode_pkg::exc_flags_t    exc_o,
    output logic                      killed_o
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_o    <= '0;
            issue_o.op <= rv_isa_pkg::NOP;
            exc_o      <= '0;
            killed_o   <= 1'b0;
        end else if (enable_i) begin
            // Bubble keeps the payload, only the op is dropped
            issue_o.op       <= (hazard_i || killed_i) ? rv_isa_pkg::NOP : op_i;
            issue_o.rd       <= instr_i.instr[11:7];
            issue_o.rs1_data <= rs1_val_i;
            issue_o.rs2_data <= rs2_val_i;
            issue_o.second   <= second_i;
            issue_o.pc       <= instr_i.pc;
            issue_o.instr    <= instr_i.instr;
            issue_o.target   <= target_i;
            issue_o.link     <= instr_i.pc + 32'd4;   // Return address for JAL/JALR
            exc_o            <= exc_i;
            killed_o         <= killed_i;
        end
    end

endmodule

// ==== decode_stage.sv ====
/*
 * RV32 decode stage
 * Decode, operand forwarding, hazard check and issue to execute
 */

`timescale 1ns/1ns

module decode_stage #(
    parameter bit MUL_ENABLE = 1'b1,
    parameter bit COMPRESSED = 1'b0
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  decode_pkg::fetch_packet_t fetch_i,
    input  logic                      enable_i,
    input  logic                      flush_i,
    input  decode_pkg::xlen_t         rs1_data_i,
    input  decode_pkg::xlen_t         rs2_data_i,
    input  decode_pkg::retire_fwd_t   retire_i,
    input  decode_pkg::exec_fwd_t     exec_i,
    output decode_pkg::reg_addr_t     rs1_addr_o,
    output decode_pkg::reg_addr_t     rs2_addr_o,
    output logic                      hazard_o,
    output decode_pkg::issue_packet_t issue_o,
    output decode_pkg::exc_flags_t    exc_o,
    output logic                      killed_o
);

    rv_isa_pkg::op_e        op;
    rv_isa_pkg::format_e    format;
    logic                   illegal;
    logic                   kill;
    decode_pkg::xlen_t      rs1_val;
    decode_pkg::xlen_t      rs2_val;
    decode_pkg::xlen_t      second;
    decode_pkg::xlen_t      target;
    decode_pkg::exc_flags_t exc_now;

    // Register file read addresses
    assign rs1_addr_o = fetch_i.instr[19:15];
    assign rs2_addr_o = fetch_i.instr[24:20];

    op_decoder #(
        .MUL_ENABLE(MUL_ENABLE)
    ) u_op_decoder (
        .instr_i   (fetch_i.instr),
        .op_o      (op),
        .format_o  (format),
        .illegal_o (illegal)
    );

    operand_unit u_operand_unit (
        .instr_i     (fetch_i.instr),
        .pc_i        (fetch_i.pc),
        .format_i    (format),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .retire_i    (retire_i),
        .exec_i      (exec_i),
        .issued_rd_i (issue_o.rd),   // Destination of the result in execute
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val),
        .second_o    (second),
        .target_o    (target)
    );

    hazard_unit #(
        .COMPRESSED(COMPRESSED)
    ) u_hazard_unit (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable_i       (enable_i),
        .instr_i        (fetch_i.instr),
        .format_i       (format),
        .flush_i        (flush_i),
        .access_fault_i (fetch_i.access_fault),
        .illegal_i      (illegal),
        .pc_i           (fetch_i.pc),
        .hazard_o       (hazard_o),
        .killed_o       (kill),
        .exc_o          (exc_now)
    );

    issue_reg u_issue_reg (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable_i  (enable_i),
        .hazard_i  (hazard_o),
        .killed_i  (kill),
        .op_i      (op),
        .instr_i   (fetch_i),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .second_i  (second),
        .target_i  (target),
        .exc_i     (exc_now),
        .issue_o   (issue_o),
        .exc_o     (exc_o),
        .killed_o  (killed_o)
    );

endmodule

// ==== tb_checks.svh ====
/*
 * Testbench compare tasks
 * One task per result type of the decode stage, plus the stop helper
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_with_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "decode stage test stopped");
endtask

task automatic check_op(input string name, input rv_isa_pkg::op_e exp,
                        input rv_isa_pkg::op_e act);
    if (act !== exp) begin
        $display("MISMATCH t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
        stop_with_error("operation differs");
    end
endtask

task automatic check_word(input string name, input decode_pkg::xlen_t exp,
                          input decode_pkg::xlen_t act);
    if (act !== exp) begin
        $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
        stop_with_error("data word differs");
    end
endtask

task automatic check_addr(input string name, input decode_pkg::reg_addr_t exp,
                          input decode_pkg::reg_addr_t act);
    if (act !== exp) begin
        $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
        stop_with_error("register index differs");
    end
endtask

task automatic check_exc(input string name, input decode_pkg::exc_flags_t exp,
                         input decode_pkg::exc_flags_t act);
    if (act !== exp) begin
        $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
        stop_with_error("exception flags differ");
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
        stop_with_error("control bit differs");
    end
endtask

`endif

// ==== tb_decode.sv ====
/*
 * Decode stage testbench
 * Replays golden vectors with random stall cycles in between
 */

`timescale 1ns/1ns

module tb_decode;

    localparam int MAX_LINES = 200;   // Bound on the file read loop

    logic                      clk;
    logic                      reset_n;
    decode_pkg::fetch_packet_t fetch_i;
    logic                      enable_i;
    logic                      flush_i;
    decode_pkg::xlen_t         rs1_data_i;
    decode_pkg::xlen_t         rs2_data_i;
    decode_pkg::retire_fwd_t   retire_i;
    decode_pkg::exec_fwd_t     exec_i;
    decode_pkg::reg_addr_t     rs1_addr_o;
    decode_pkg::reg_addr_t     rs2_addr_o;
    logic                      hazard_o;
    decode_pkg::issue_packet_t issue_o;
    decode_pkg::exc_flags_t    exc_o;
    logic                      killed_o;

    integer seed = 19;

    `include "tb_checks.svh"

    decode_stage dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_i    (fetch_i),
        .enable_i   (enable_i),
        .flush_i    (flush_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .retire_i   (retire_i),
        .exec_i     (exec_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .hazard_o   (hazard_o),
        .issue_o    (issue_o),
        .exc_o      (exc_o),
        .killed_o   (killed_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Priority order of the forwarding paths
    function automatic decode_pkg::xlen_t expected_operand(
        input decode_pkg::reg_addr_t src,
        input decode_pkg::xlen_t     rf_data,
        input logic                  ex_we,
        input decode_pkg::reg_addr_t ex_rd,
        input decode_pkg::xlen_t     ex_result,
        input logic                  rt_we,
        input decode_pkg::reg_addr_t rt_rd,
        input decode_pkg::xlen_t     rt_data
    );
        decode_pkg::xlen_t val;
        val = rf_data;
        if (src != '0) begin   // x0 always reads the register file
            if (ex_we && src == ex_rd)
                val = ex_result;
            else if (rt_we && src == rt_rd)
                val = rt_data;
        end
        return val;
    endfunction

    ////////////////////////////////////////
    // Stall cycles, issue outputs must hold
    ////////////////////////////////////////

    task automatic stall_random;
        int                        idle;
        decode_pkg::issue_packet_t held;
        decode_pkg::exc_flags_t    held_exc;
        logic                      held_kill;
        idle      = $random(seed) & 32'h3;
        held      = issue_o;
        held_exc  = exc_o;
        held_kill = killed_o;
        for (int i = 0; i < idle; i++) begin
            @(posedge clk);
            enable_i <= 1'b0;
            @(negedge clk);
            check_op("issue_o.op (stalled)", held.op, issue_o.op);
            check_addr("issue_o.rd (stalled)", held.rd, issue_o.rd);
            check_word("issue_o.rs1_data (stalled)", held.rs1_data, issue_o.rs1_data);
            check_word("issue_o.rs2_data (stalled)", held.rs2_data, issue_o.rs2_data);
            check_word("issue_o.second (stalled)", held.second, issue_o.second);
            check_word("issue_o.pc (stalled)", held.pc, issue_o.pc);
            check_word("issue_o.instr (stalled)", held.instr, issue_o.instr);
            check_word("issue_o.target (stalled)", held.target, issue_o.target);
            check_word("issue_o.link (stalled)", held.link, issue_o.link);
            check_exc("exc_o (stalled)", held_exc, exc_o);
            check_bit("killed_o (stalled)", held_kill, killed_o);
        end
    endtask

    initial begin
        int                    fd;
        int                    rc;
        int                    n_vec;
        int                    lines;
        string                 line;
        logic [31:0]           f_instr;
        logic [31:0]           f_pc;
        logic [31:0]           f_rs1d;
        logic [31:0]           f_rs2d;
        logic [31:0]           f_rtdata;
        logic [31:0]           f_exres;
        logic [31:0]           e_rs1;
        logic [31:0]           e_second;
        logic [31:0]           e_target;
        logic [31:0]           e_link;
        logic [4:0]            f_rtrd;
        logic [2:0]            e_exc;
        logic                  f_af;
        logic                  f_fl;
        logic                  f_rtwe;
        logic                  f_exwe;
        logic                  e_hz;
        logic                  e_kl;
        int                    e_op;
        decode_pkg::xlen_t     e_rs2;
        decode_pkg::reg_addr_t last_rd;

        // Every input starts at a known value
        reset_n    = 1'b0;
        fetch_i    = '0;
        enable_i   = 1'b0;
        flush_i    = 1'b0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        retire_i   = '0;
        exec_i     = '0;
        n_vec      = 0;
        lines      = 0;
        last_rd    = '0;   // Issue rd after reset

        for (int i = 0; i < 5; i++)
            @(posedge clk);
        reset_n <= 1'b1;

        fd = $fopen("decode_golden.txt", "r");
        if (fd == 0)
            stop_with_error("cannot open decode_golden.txt");

        while (!$feof(fd)) begin
            lines++;
            if (lines > MAX_LINES)
                stop_with_error("golden file has too many lines, end of file not reached");
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 4 || line[0] == "#")
                continue;   // Comment or blank line
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h %h",
                         f_instr, f_pc, f_af, f_fl, f_rs1d, f_rs2d, f_rtwe, f_rtrd,
                         f_rtdata, f_exwe, f_exres, e_op, e_rs1, e_second, e_target,
                         e_link, e_exc, e_hz, e_kl);
            if (rc != 19)
                stop_with_error($sformatf("golden line %0d does not parse", lines));

            e_rs2 = expected_operand(f_instr[24:20], f_rs2d, f_exwe, last_rd, f_exres,
                                     f_rtwe, f_rtrd, f_rtdata);

            stall_random();

            @(posedge clk);
            fetch_i    <= '{instr: f_instr, pc: f_pc, access_fault: f_af};
            flush_i    <= f_fl;
            rs1_data_i <= f_rs1d;
            rs2_data_i <= f_rs2d;
            retire_i   <= '{we: f_rtwe, rd: f_rtrd, data: f_rtdata};
            exec_i     <= '{we: f_exwe, result: f_exres};
            enable_i   <= 1'b1;

            @(negedge clk);
            check_bit("hazard_o", e_hz, hazard_o);   // Same cycle as the instruction
            check_addr("rs1_addr_o", f_instr[19:15], rs1_addr_o);
            check_addr("rs2_addr_o", f_instr[24:20], rs2_addr_o);

            @(posedge clk);
            enable_i <= 1'b0;
            // Scrambled fetch packet while enable is low
            fetch_i  <= '{instr: ~f_instr, pc: ~f_pc, access_fault: ~f_af};
            @(negedge clk);
            check_op("issue_o.op", rv_isa_pkg::op_e'(e_op), issue_o.op);
            check_addr("issue_o.rd", f_instr[11:7], issue_o.rd);
            check_word("issue_o.rs1_data", e_rs1, issue_o.rs1_data);
            check_word("issue_o.rs2_data", e_rs2, issue_o.rs2_data);
            check_word("issue_o.second", e_second, issue_o.second);
            check_word("issue_o.pc", f_pc, issue_o.pc);
            check_word("issue_o.instr", f_instr, issue_o.instr);
            check_word("issue_o.target", e_target, issue_o.target);
            check_word("issue_o.link", e_link, issue_o.link);
            check_exc("exc_o", e_exc, exc_o);
            check_bit("killed_o", e_kl, killed_o);
            last_rd = f_instr[11:7];
            n_vec++;
        end
        $fclose(fd);

        if (n_vec > 0) begin
            $display("Checked %0d vectors", n_vec);
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_error("golden file ended before any vector was read");
        end
    end

endmodule

// ==== decode_golden.txt ====
# instr pc af flush rs1_data rs2_data rt_we rt_rd rt_data ex_we ex_result | op rs1 second target link exc hazard killed
# hex fields, op as decimal op_e index, exc as {illegal,misaligned,access_fault}
fff10093 00001000 0 0 11111111 22222222 0 00 00000000 0 00000000 1 11111111 ffffffff 00000fff 00001004 0 0 0
002081b3 00001004 0 0 11111111 22222222 1 01 bbbbbbbb 1 aaaaaaaa 1 aaaaaaaa 22222222 00001004 00001008 0 0 0
40328033 00001008 0 0 11111111 22222222 1 05 cccccccc 0 00000000 2 cccccccc 22222222 00001008 0000100c 0 0 0
00006333 0000100c 0 0 11111111 22222222 1 00 eeeeeeee 1 dddddddd 9 11111111 22222222 0000100c 00001010 0 0 0
123453b7 00001010 0 0 11111111 22222222 0 00 00000000 0 00000000 25 11111111 12345000 12346010 00001014 0 0 0
00001417 00001014 0 0 11111111 22222222 0 00 00000000 0 00000000 26 11111111 00001000 00002014 00001018 0 0 0
008000ef 00001018 0 0 11111111 22222222 0 00 00000000 0 00000000 27 11111111 22222222 00001020 0000101c 0 0 0
fe208ee3 0000101c 0 0 11111111 22222222 0 00 00000000 1 12121212 11 12121212 22222222 00001018 00001020 0 0 0
00812483 00001020 0 0 11111111 22222222 0 00 00000000 0 00000000 19 11111111 00000008 00001028 00001024 0 0 0
00048533 00001024 0 0 11111111 22222222 0 00 00000000 0 00000000 0 11111111 22222222 00001024 00001028 0 1 0
00048533 00001024 0 0 11111111 22222222 1 09 99999999 0 00000000 1 99999999 22222222 00001024 00001028 0 0 0
00a0a223 00001028 0 0 11111111 22222222 0 00 00000000 0 00000000 24 11111111 00000004 0000102c 0000102c 0 0 0
00812483 0000102c 0 0 11111111 22222222 0 00 00000000 0 00000000 0 11111111 00000008 00001034 00001030 0 1 0
00812483 0000102c 0 0 11111111 22222222 0 00 00000000 0 00000000 19 11111111 00000008 00001034 00001030 0 0 0
00048533 00001030 0 1 11111111 22222222 0 00 00000000 0 00000000 0 11111111 22222222 00001030 00001034 0 0 1
00048533 00001030 0 0 11111111 22222222 0 00 00000000 0 00000000 1 11111111 22222222 00001030 00001034 0 0 0
00000010 00001034 0 0 11111111 22222222 0 00 00000000 0 00000000 1 11111111 00000000 00001034 00001038 4 0 0
0000007f 00001038 0 0 11111111 22222222 0 00 00000000 0 00000000 47 11111111 22222222 00001038 0000103c 4 0 0
fff10093 00001042 0 0 11111111 22222222 0 00 00000000 0 00000000 1 11111111 ffffffff 00001041 00001046 2 0 0
00812483 00001044 1 0 11111111 22222222 0 00 00000000 0 00000000 19 11111111 00000008 0000104c 00001048 1 0 0
00048533 00001048 1 0 11111111 22222222 0 00 00000000 0 00000000 1 11111111 22222222 00001048 0000104c 1 0 0
022085b3 0000104c 0 0 11111111 22222222 0 00 00000000 0 00000000 39 11111111 22222222 0000104c 00001050 0 0 0
0220d633 00001050 0 0 11111111 22222222 0 00 00000000 0 00000000 44 11111111 22222222 00001050 00001054 0 0 0
300092f3 00001054 0 0 11111111 22222222 0 00 00000000 0 00000000 33 11111111 22222222 00001054 00001058 0 0 0
00000073 00001058 0 0 11111111 22222222 0 00 00000000 0 00000000 29 11111111 22222222 00001058 0000105c 0 0 0
30200073 0000105c 0 0 11111111 22222222 0 00 00000000 0 00000000 31 11111111 22222222 0000105c 00001060 0 0 0

// ==== tb.f ====
+incdir+.
rv_isa_pkg.sv
decode_pkg.sv
op_decoder.sv
operand_unit.sv
hazard_unit.sv
issue_reg.sv
decode_stage.sv
tb_decode.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

OBJ_DIR = obj_dir

all: run

run:
	verilator --binary --timing -f tb.f --top-module tb_decode -Mdir $(OBJ_DIR) -o tb_decode
	./$(OBJ_DIR)/tb_decode

lint:
	verilator --lint-only -Wall -f tb.f --top-module decode_stage

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all run lint clean
